/* verilog.f */
+incdir+.
bcfg_pkg.sv
bcfg_regs.sv
bcfg_sampler.sv
bcfg_bus.sv
bcfg_top.sv
tb_bcfg_top.sv

/* tb_bcfg_top.sv */
// simulation testbench for bcfg_top that checks random wishbone traffic against a register-map model
`timescale 1ns/1ps
`default_nettype none

`include "bcfg_consts.svh"

module tb_bcfg_top;

    import bcfg_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;   // full run is about 1000 cycles

    logic      sysclk;
    logic      rst_n;
    board_id_t board_id;
    quad_t     io_in;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    reg_addr_t wb_adr;
    quad_t     wb_dat_w;
    quad_t     wb_dat_r;
    logic      wb_ack;
    quad_t     io_out;
    quad_t     io_oe;

    // model of the register map
    quad_t rng_state;
    quad_t exp_io_out;
    quad_t exp_io_oe;
    quad_t exp_io_in;
    int    exp_seq;         // completed sample runs
    quad_t last_ts;         // newest timestamp read
    quad_t buf_copy [8];    // buffer as read after the last run

    int cycles = 0;
    int errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    bcfg_top u_bcfg_top (
        .sysclk   (sysclk),
        .rst_n    (rst_n),
        .board_id (board_id),
        .io_in    (io_in),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .io_out   (io_out),
        .io_oe    (io_oe)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;    // 4 ns period
    end

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no bus or sampler progress within %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // 32-bit xorshift
    function automatic quad_t next_random();
        quad_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_quad(input string name, input quad_t exp, input quad_t act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // one classic cycle with outputs sampled just before the edge after ack
    task automatic bus_access(input logic we, input reg_addr_t addr, input quad_t wdata,
                              output quad_t rdata);
        @(posedge sysclk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_dat_w <= wdata;
        @(posedge sysclk);
        while (!wb_ack)
            @(posedge sysclk);
        rdata = wb_dat_r;   // registered with the ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input reg_addr_t addr, input quad_t data);
        quad_t unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input reg_addr_t addr, output quad_t data);
        bus_access(1'b0, addr, '0, data);
    endtask

    task automatic read_check(input reg_addr_t addr, input string name, input quad_t exp);
        quad_t rd;
        bus_read(addr, rd);
        check_quad(name, exp, rd);
    endtask

    // timestamp must move forward on every read
    task automatic read_timestamp(output quad_t ts);
        bus_read(`BCFG_REG_TIMESTAMP, ts);
        assert (ts > last_ts) else begin
            $display("[FAIL] timestamp %h not above previous %h", ts, last_ts);
            errors++;
        end
        last_ts = ts;
    endtask

    task automatic set_io_in(input quad_t v);
        @(posedge sysclk);
        io_in <= v;
        exp_io_in = v;
        repeat (3) @(posedge sysclk);   // past the two-flop sync
    endtask

    // start a run, wait for busy to drop, read the buffer back and check it
    task automatic run_and_check(input sample_chan_t chan, input logic extra_start);
        quad_t ts_before;
        quad_t ts_after;
        quad_t rd;
        quad_t exp_head;
        exp_head = {exp_seq[15:0], 12'h000, chan};  // run index and channel
        read_timestamp(ts_before);
        bus_write(`BCFG_REG_SAMPLE, {28'd0, chan});
        if (extra_start)
            bus_write(`BCFG_REG_SAMPLE, {28'd0, ~chan});    // lands while busy
        do
            bus_read(`BCFG_REG_SAMPLE, rd);
        while (rd[31]);
        check_quad("sample_reg", {28'd0, chan}, rd);
        read_timestamp(ts_after);
        for (int i = 0; i < 8; i++)
            bus_read(`BCFG_SAMPLE_BASE | reg_addr_t'(i), buf_copy[i]);
        check_quad("entry0", exp_head, buf_copy[0]);
        assert (buf_copy[1] > ts_before && buf_copy[1] < ts_after) else begin
            $display("[FAIL] entry1 %h not between %h and %h", buf_copy[1], ts_before, ts_after);
            errors++;
        end
        check_quad("entry2", exp_io_in, buf_copy[2]);
        check_quad("entry3", exp_io_out, buf_copy[3]);
        // checksum over the modelled quadlets and the range-checked timestamp
        check_quad("entry4", exp_head ^ buf_copy[1] ^ exp_io_in ^ exp_io_out, buf_copy[4]);
        for (int i = 5; i < 8; i++)
            check_quad("entry_unused", '0, buf_copy[i]);
        exp_seq++;
    endtask

    task automatic end_test(input string name, input int err_at_start);
        if (errors == err_at_start) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - err_at_start);
            tests_bad++;
        end
    endtask

    initial begin
        quad_t     v;
        quad_t     ts;
        reg_addr_t a;
        int        e0;
        rng_state  = 32'hfefee41f;
        rst_n      = 1'b0;
        board_id   = board_id_t'(next_random());
        io_in      = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        exp_io_out = '0;
        exp_io_oe  = '0;
        exp_io_in  = '0;
        exp_seq    = 0;
        last_ts    = '0;
        repeat (2) @(posedge sysclk);
        rst_n <= 1'b1;

        e0 = errors;
        @(posedge sysclk);
        check_quad("wb_ack", '0, {31'd0, wb_ack});
        check_quad("io_out", '0, io_out);
        check_quad("io_oe", '0, io_oe);
        read_check(`BCFG_REG_STATUS, "status", {`BCFG_FW_VERSION, 12'h000, board_id});
        read_check(`BCFG_REG_SAMPLE, "sample_reg", '0);     // idle with channel 0
        end_test("reset", e0);

        e0 = errors;
        for (int n = 0; n < 20; n++) begin
            exp_io_out = next_random();
            exp_io_oe  = next_random();
            bus_write(`BCFG_REG_IO_OUT, exp_io_out);
            check_quad("io_out", exp_io_out, io_out);
            bus_write(`BCFG_REG_IO_OE, exp_io_oe);
            check_quad("io_oe", exp_io_oe, io_oe);
            read_check(`BCFG_REG_IO_OUT, "io_out_reg", exp_io_out);
            read_check(`BCFG_REG_IO_OE, "io_oe_reg", exp_io_oe);
        end
        end_test("output registers", e0);

        e0 = errors;
        for (int n = 0; n < 20; n++) begin
            set_io_in(next_random());
            read_check(`BCFG_REG_IO_IN, "io_in_reg", exp_io_in);
        end
        end_test("input sync", e0);

        e0 = errors;
        for (int n = 0; n < 8; n++) begin
            exp_io_out = next_random();
            bus_write(`BCFG_REG_IO_OUT, exp_io_out);
            set_io_in(next_random());
            run_and_check(sample_chan_t'(next_random()), 1'b0);
        end
        end_test("sample runs", e0);

        e0 = errors;
        for (int n = 0; n < 10; n++)
            read_timestamp(ts);
        end_test("timestamp order", e0);

        e0 = errors;
        for (int n = 0; n < 6; n++) begin
            v = next_random();
            a = v[15:0] & ~`BCFG_SAMPLE_BASE;
            if (a < 16'd6)
                a = a + 16'd6;      // skip the mapped registers
            read_check(a, "unmapped", '0);
        end
        bus_write(`BCFG_REG_STATUS, next_random());
        bus_write(`BCFG_REG_IO_IN, next_random());
        bus_write(`BCFG_REG_TIMESTAMP, '0);
        for (int i = 0; i < 8; i++)
            bus_write(`BCFG_SAMPLE_BASE | reg_addr_t'(i), next_random());
        read_check(`BCFG_REG_STATUS, "status", {`BCFG_FW_VERSION, 12'h000, board_id});
        read_check(`BCFG_REG_IO_IN, "io_in_reg", exp_io_in);
        read_check(`BCFG_REG_IO_OUT, "io_out_reg", exp_io_out);
        read_check(`BCFG_REG_IO_OE, "io_oe_reg", exp_io_oe);
        read_timestamp(ts);         // a zero write would show as a step back
        for (int i = 0; i < 8; i++)
            read_check(`BCFG_SAMPLE_BASE | reg_addr_t'(i), "buffer", buf_copy[i]);
        run_and_check(sample_chan_t'(next_random()), 1'b1);
        run_and_check(sample_chan_t'(next_random()), 1'b1);
        end_test("ignored accesses", e0);

        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bcfg_top.sv */
// boot-config block top level, wires the wishbone bus unit to the register file and sampler
`timescale 1ns/1ps
`default_nettype none

module bcfg_top (
    input  wire                      sysclk,
    input  wire                      rst_n,
    input  wire bcfg_pkg::board_id_t board_id,
    input  wire bcfg_pkg::quad_t     io_in,     // connector inputs from pad wrapper
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire bcfg_pkg::reg_addr_t wb_adr,
    input  wire bcfg_pkg::quad_t     wb_dat_w,
    output wire bcfg_pkg::quad_t     wb_dat_r,
    output wire                      wb_ack,
    output wire bcfg_pkg::quad_t     io_out,
    output wire bcfg_pkg::quad_t     io_oe      // tristate enables for the wrapper
);

    import bcfg_pkg::*;

    // internal register bus
    reg_addr_t reg_addr;
    quad_t     reg_wdata;
    logic      reg_wen;
    quad_t     reg_rdata;
    quad_t     sample_rdata;

    // register file to sampler
    logic         sample_start;
    logic         sample_busy;
    sample_chan_t sample_chan;
    quad_t        io_in_sync;
    quad_t        timestamp;

    bcfg_bus u_bus (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .reg_rdata    (reg_rdata),
        .sample_rdata (sample_rdata),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .samp_sel     ()            // select folded into reg_wen
    );

    bcfg_regs u_regs (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .board_id     (board_id),
        .io_in        (io_in),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .sample_busy  (sample_busy),
        .reg_rdata    (reg_rdata),
        .io_out       (io_out),
        .io_oe        (io_oe),
        .io_in_sync   (io_in_sync),
        .sample_start (sample_start),
        .sample_chan  (sample_chan),
        .timestamp    (timestamp)
    );

    bcfg_sampler u_sampler (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .sample_chan  (sample_chan),
        .io_in_sync   (io_in_sync),
        .io_out       (io_out),
        .timestamp    (timestamp),
        .reg_addr     (reg_addr),
        .sample_rdata (sample_rdata),
        .sample_busy  (sample_busy)
    );

endmodule

`default_nettype wire

/* bcfg_bus.sv */
// wishbone classic slave for the boot-config block, decodes accesses and merges read data
`timescale 1ns/1ps
`default_nettype none

`include "bcfg_consts.svh"

module bcfg_bus (
    input  wire                      sysclk,
    input  wire                      rst_n,
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire bcfg_pkg::reg_addr_t wb_adr,        // quadlet address
    input  wire bcfg_pkg::quad_t     wb_dat_w,
    input  wire bcfg_pkg::quad_t     reg_rdata,     // from register file
    input  wire bcfg_pkg::quad_t     sample_rdata,  // from sample buffer
    output bcfg_pkg::quad_t          wb_dat_r,
    output logic                     wb_ack,
    output bcfg_pkg::reg_addr_t      reg_addr,
    output bcfg_pkg::quad_t          reg_wdata,
    output logic                     reg_wen,
    output logic                     samp_sel
);

    import bcfg_pkg::*;

    logic  req_new;     // request seen, not yet acked
    quad_t rd_mux;

    // every access completes one clock after it is sampled
    assign req_new = wb_cyc & wb_stb & ~wb_ack;

    // bit 12 picks the buffer window
    assign samp_sel = ((wb_adr & `BCFG_SAMPLE_BASE) != 16'h0000);

    assign reg_addr  = wb_adr;
    assign reg_wdata = wb_dat_w;

    // write pulse lands on the acking edge; buffer window writes are dropped
    assign reg_wen = req_new & wb_we & ~samp_sel;

    assign rd_mux = samp_sel ? sample_rdata : reg_rdata;

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= req_new;  // single-cycle ack
    end

    // read data captured with the ack, held until next access
    always_ff @(posedge sysclk) begin
        if (req_new)
            wb_dat_r <= rd_mux;
    end

endmodule

`default_nettype wire

/* bcfg_sampler.sv */
// block-read sampler, snapshots board state into a quadlet buffer on sample_start from bcfg_regs
`timescale 1ns/1ps
`default_nettype none

`include "bcfg_consts.svh"

module bcfg_sampler (
    input  wire                      sysclk,
    input  wire                      rst_n,
    input  wire                      sample_start,  // one-cycle pulse
    input  wire bcfg_pkg::sample_chan_t sample_chan,
    input  wire bcfg_pkg::quad_t     io_in_sync,
    input  wire bcfg_pkg::quad_t     io_out,
    input  wire bcfg_pkg::quad_t     timestamp,
    input  wire bcfg_pkg::reg_addr_t reg_addr,      // low bits index the buffer
    output bcfg_pkg::quad_t          sample_rdata,
    output logic                     sample_busy
);

    import bcfg_pkg::*;

    samp_state_t  state;
    sample_addr_t wr_idx;       // next buffer entry to fill
    sample_addr_t rd_idx;
    logic [15:0]  seq_num;      // completed runs
    logic         last_quad;    // checksum cycle
    logic         accept;       // start taken this cycle

    // snapshot taken when the run starts
    sample_chan_t snap_chan;
    quad_t        snap_ts;
    quad_t        snap_in;
    quad_t        snap_out;

    quad_t csum;        // running xor of entries 0..3
    quad_t fill_data;   // quadlet written this cycle
    quad_t buffer [`BCFG_SAMPLE_DEPTH];

    assign accept      = sample_start && (state == SAMP_IDLE);  // start while busy dropped
    assign last_quad   = (wr_idx == sample_addr_t'(`BCFG_NUM_BC_READ_QUADS - 1));
    assign sample_busy = (state == SAMP_FILL);

    // fsm, fill index and sequence count
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state   <= SAMP_IDLE;
            wr_idx  <= '0;
            seq_num <= '0;
        end else begin
            case (state)
                SAMP_IDLE: begin
                    wr_idx <= '0;
                    if (accept)
                        state <= SAMP_FILL;
                end
                SAMP_FILL: begin
                    wr_idx <= wr_idx + 3'd1;
                    if (last_quad) begin
                        state   <= SAMP_IDLE;
                        seq_num <= seq_num + 16'd1;    // bump at end of run
                    end
                end
                default: state <= SAMP_IDLE;
            endcase
        end
    end

    // quadlet order: seq/chan, timestamp, inputs, outputs, checksum
    always_comb begin
        case (wr_idx)
            3'd0:    fill_data = {seq_num, 12'h000, snap_chan};
            3'd1:    fill_data = snap_ts;
            3'd2:    fill_data = snap_in;
            3'd3:    fill_data = snap_out;
            default: fill_data = csum;
        endcase
    end

    // snapshot, checksum and buffer writes
    always_ff @(posedge sysclk) begin
        if (accept) begin
            snap_chan <= sample_chan;
            snap_ts   <= timestamp;
            snap_in   <= io_in_sync;
            snap_out  <= io_out;
        end
        if (sample_busy) begin
            buffer[wr_idx] <= fill_data;
            csum <= (wr_idx == 3'd0) ? fill_data : (csum ^ fill_data);
        end
    end

    // combinational buffer read, entries past the block give zero
    assign rd_idx = reg_addr[2:0];
    assign sample_rdata = (rd_idx < sample_addr_t'(`BCFG_NUM_BC_READ_QUADS)) ?
                          buffer[rd_idx] : '0;

endmodule

`default_nettype wire

/* bcfg_regs.sv */
// board configuration register file with input sync and timestamp, driven by the bcfg_bus write pulse
`timescale 1ns/1ps
`default_nettype none

`include "bcfg_consts.svh"

module bcfg_regs (
    input  wire                    sysclk,
    input  wire                    rst_n,
    input  wire bcfg_pkg::board_id_t board_id,    // from rotary switch
    input  wire bcfg_pkg::quad_t   io_in,         // raw connector inputs
    input  wire bcfg_pkg::reg_addr_t reg_addr,
    input  wire bcfg_pkg::quad_t   reg_wdata,
    input  wire                    reg_wen,       // only set for register window
    input  wire                    sample_busy,
    output bcfg_pkg::quad_t        reg_rdata,
    output bcfg_pkg::quad_t        io_out,
    output bcfg_pkg::quad_t        io_oe,
    output bcfg_pkg::quad_t        io_in_sync,
    output logic                   sample_start,
    output bcfg_pkg::sample_chan_t sample_chan,
    output bcfg_pkg::quad_t        timestamp
);

    import bcfg_pkg::*;

    quad_t io_in_meta;  // first synchronizer stage
    logic  wr_sample;   // host write to the sample register

    assign wr_sample = reg_wen && (reg_addr == `BCFG_REG_SAMPLE);

    // control state and host-writable registers
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            io_out       <= '0;
            io_oe        <= '0;
            sample_start <= 1'b0;
            sample_chan  <= '0;
            timestamp    <= '0;
        end else begin
            timestamp    <= timestamp + 32'd1;          // runs every cycle
            sample_start <= wr_sample & ~sample_busy;   // one-cycle start pulse
            if (reg_wen) begin
                case (reg_addr)
                    `BCFG_REG_IO_OUT: io_out <= reg_wdata;
                    `BCFG_REG_IO_OE:  io_oe  <= reg_wdata;
                    `BCFG_REG_SAMPLE: begin
                        // keep channel of the active run
                        if (!sample_busy)
                            sample_chan <= reg_wdata[3:0];
                    end
                    default: ;  // status, io_in, timestamp are read-only
                endcase
            end
        end
    end

    // two-flop sync on the connector inputs
    always_ff @(posedge sysclk) begin
        io_in_meta <= io_in;
        io_in_sync <= io_in_meta;   // visible two cycles after a change
    end

    // read decode, unmapped addresses give zero
    always_comb begin
        case (reg_addr)
            `BCFG_REG_STATUS:    reg_rdata = {`BCFG_FW_VERSION, 12'h000, board_id};
            `BCFG_REG_IO_OUT:    reg_rdata = io_out;
            `BCFG_REG_IO_OE:     reg_rdata = io_oe;
            `BCFG_REG_IO_IN:     reg_rdata = io_in_sync;
            `BCFG_REG_SAMPLE:    reg_rdata = {sample_busy, 27'd0, sample_chan};
            `BCFG_REG_TIMESTAMP: reg_rdata = timestamp;
            default:             reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* bcfg_pkg.sv */
// shared types for the boot-config block, imported by the rtl and the testbench
`default_nettype none

package bcfg_pkg;

    // one register or buffer quadlet
    typedef logic [31:0] quad_t;

    // quadlet address on the register bus
    typedef logic [15:0] reg_addr_t;

    typedef logic [3:0] board_id_t;     // rotary switch value
    typedef logic [3:0] sample_chan_t;  // channel carried through a run
    typedef logic [2:0] sample_addr_t;  // sample buffer index

    // sampler fsm
    typedef enum logic [0:0] {
        SAMP_IDLE = 1'b0,   // waiting for a start
        SAMP_FILL = 1'b1    // writing one quadlet per cycle
    } samp_state_t;

endpackage

`default_nettype wire

/* bcfg_consts.svh */
// register map and sizing macros for the boot-config block, include where addresses are decoded
`ifndef BCFG_CONSTS_SVH
`define BCFG_CONSTS_SVH

// quadlet addresses of the board config registers
`define BCFG_REG_STATUS     16'h0000  // version[31:16], board id[3:0]
`define BCFG_REG_IO_OUT     16'h0001  // connector output value
`define BCFG_REG_IO_OE      16'h0002  // connector output enable
`define BCFG_REG_IO_IN      16'h0003  // synchronized connector inputs, read-only
`define BCFG_REG_SAMPLE     16'h0004  // write starts a run, read gives busy and channel
`define BCFG_REG_TIMESTAMP  16'h0005  // free-running counter, read-only

// sample buffer window, bit 12 of the quadlet address
`define BCFG_SAMPLE_BASE    16'h1000

// buffer sizing
`define BCFG_SAMPLE_DEPTH       8   // entries in the buffer
`define BCFG_NUM_BC_READ_QUADS  5   // seq/chan, timestamp, io_in, io_out, checksum

// reported in the status word
`define BCFG_FW_VERSION     16'h0b0c

`endif
